// ==== design/video_pkg.sv ====
//////////////////////////////////////////////////
// video package
// raster geometry, field widths and the colour
// type shared by the lcd video blocks
//////////////////////////////////////////////////

package video_pkg;

  ////////////////////////////////////////////////
  // widths

  // x and y counter width
  localparam int count_width = 10;
  // pixel memory geometry
  localparam int pix_addr_width = 8;
  localparam int pix_depth = 1 << pix_addr_width;
  localparam int pix_data_width = 4;

  typedef logic [count_width-1:0] count_t;
  typedef logic [pix_addr_width-1:0] pix_addr_t;
  typedef logic [pix_data_width-1:0] pix_data_t;

  ////////////////////////////////////////////////
  // raster geometry, 400 x 512 = 204800 per frame

  // horizontal, in pixel clocks
  localparam count_t h_total = count_t'(400);
  localparam count_t h_active = count_t'(320);
  localparam count_t h_bporch = count_t'(10);
  // vertical, in lines
  localparam count_t v_total = count_t'(512);
  localparam count_t v_active = count_t'(240);
  localparam count_t v_bporch = count_t'(10);
  // hs lands a few clocks after vs, never on the same cycle
  localparam count_t hs_position = count_t'(3);

  ////////////////////////////////////////////////
  // colour

  // gray level used for a lit pixel
  localparam logic [7:0] lit_level = 8'd60;

  // 24-bit rgb, red in the top byte
  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } rgb_t;

endpackage

// ==== design/raster_if.sv ====
//////////////////////////////////////////////////
// raster interface
// raster position, visible window and the
// frame and line strobes from the timing block
//////////////////////////////////////////////////

interface raster_if;

  // current raster position
  video_pkg::count_t x_count;
  video_pkg::count_t y_count;

  // inside the 320 x 240 window
  logic visible;
  // x and y both zero
  logic frame_start;
  // fixed point in each line for hsync
  logic line_start_hs;

  // timing generator drives everything
  modport source (
    output x_count,
    output y_count,
    output visible,
    output frame_start,
    output line_start_hs
  );

  // memory and shader only look
  modport sink (
    input x_count,
    input y_count,
    input visible,
    input frame_start,
    input line_start_hs
  );

endinterface

// ==== design/raster_timing.sv ====
//////////////////////////////////////////////////
// raster timing generator
// x and y counters over the 400 x 512 frame,
// visible window decode and sync strobes
//////////////////////////////////////////////////

module raster_timing (
  input logic clk_3_276mhz,
  input logic reset_n,
  raster_if.source raster
);

  import video_pkg::*;

  // end of line and end of frame
  logic x_last;
  logic y_last;
  // window decode per axis
  logic x_in_window;
  logic y_in_window;

  ////////////////////////////////////////////////
  // counters

  assign x_last = (raster.x_count == h_total - 1'b1);
  assign y_last = (raster.y_count == v_total - 1'b1);

  // x runs every clock, y steps on the x wrap
  always_ff @(posedge clk_3_276mhz or negedge reset_n) begin
    if (!reset_n) begin
      raster.x_count <= '0;
    end else if (x_last) begin
      raster.x_count <= '0;
    end else begin
      raster.x_count <= raster.x_count + 1'b1;
    end
  end

  always_ff @(posedge clk_3_276mhz or negedge reset_n) begin
    if (!reset_n) begin
      raster.y_count <= '0;
    end else if (x_last) begin
      // wrap at the bottom of the frame
      if (y_last) begin
        raster.y_count <= '0;
      end else begin
        raster.y_count <= raster.y_count + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////
  // visible window

  // back porch first, then the active span
  assign x_in_window = (raster.x_count >= h_bporch) &&
                       (raster.x_count < h_bporch + h_active);
  assign y_in_window = (raster.y_count >= v_bporch) &&
                       (raster.y_count < v_bporch + v_active);

  assign raster.visible = x_in_window && y_in_window;

  ////////////////////////////////////////////////
  // sync strobes

  // new frame at the origin
  assign raster.frame_start = (raster.x_count == '0) && (raster.y_count == '0);

  // new line, a few clocks in so it never meets vs
  assign raster.line_start_hs = (raster.x_count == hs_position);

endmodule

// ==== design/pixel_memory.sv ====
//////////////////////////////////////////////////
// pixel memory
// 256 nibbles loaded by a write strobe and read
// back in scan order, one per visible pixel
//////////////////////////////////////////////////

module pixel_memory (
  input logic clk_3_276mhz,
  input logic reset_n,
  // write port, single cycle strobe
  input logic pixel_wr,
  input video_pkg::pix_addr_t pixel_wr_addr,
  input video_pkg::pix_data_t pixel_wr_data,
  // raster position
  raster_if.sink raster,
  // nibble at the scan address
  output video_pkg::pix_data_t pixel
);

  import video_pkg::*;

  // storage
  pix_data_t mem [pix_depth];

  // scan position into the memory
  pix_addr_t scan_addr;

  ////////////////////////////////////////////////
  // write port

  // write lands on the sampling edge
  // the pixel registered at that edge still reads the old nibble
  always_ff @(posedge clk_3_276mhz or negedge reset_n) begin
    if (!reset_n) begin
      // start from a blank screen
      for (int i = 0; i < pix_depth; i++) begin
        mem[i] <= '0;
      end
    end else if (pixel_wr) begin
      mem[pixel_wr_addr] <= pixel_wr_data;
    end
  end

  ////////////////////////////////////////////////
  // scan address

  // one step per visible pixel
  // wraps naturally at 256
  always_ff @(posedge clk_3_276mhz or negedge reset_n) begin
    if (!reset_n) begin
      scan_addr <= '0;
    end else if (raster.visible) begin
      scan_addr <= scan_addr + 1'b1;
    end
  end

  ////////////////////////////////////////////////
  // read port

  // async read, shader registers it
  assign pixel = mem[scan_addr];

endmodule

// ==== design/pixel_shader.sv ====
//////////////////////////////////////////////////
// pixel shader
// registered video outputs: colour from the
// current nibble, data enable and sync strobes
//////////////////////////////////////////////////

module pixel_shader (
  input logic clk_3_276mhz,
  input logic reset_n,
  // raster position and strobes
  raster_if.sink raster,
  // nibble for the current pixel
  input video_pkg::pix_data_t pixel,
  // video out, one clock behind the counters
  output video_pkg::rgb_t video_rgb,
  output logic video_de,
  output logic video_vs,
  output logic video_hs
);

  import video_pkg::*;

  // colour for this cycle, before the register
  rgb_t rgb_next;
  // any bit set means lit
  logic pixel_lit;

  ////////////////////////////////////////////////
  // colour select

  assign pixel_lit = (pixel != '0);

  // gray on all three channels when lit
  // black for dark pixels and everything outside the window
  always_comb begin
    rgb_next = '0;
    if (raster.visible && pixel_lit) begin
      rgb_next.red = lit_level;
      rgb_next.green = lit_level;
      rgb_next.blue = lit_level;
    end
  end

  ////////////////////////////////////////////////
  // output registers

  always_ff @(posedge clk_3_276mhz or negedge reset_n) begin
    if (!reset_n) begin
      video_rgb <= '0;
      video_de <= 1'b0;
      video_vs <= 1'b0;
      video_hs <= 1'b0;
    end else begin
      video_rgb <= rgb_next;
      // enable tracks the window
      video_de <= raster.visible;
      // one clock pulses from the timing block
      video_vs <= raster.frame_start;
      video_hs <= raster.line_start_hs;
    end
  end

endmodule

// ==== design/lcd_video_top.sv ====
//////////////////////////////////////////////////
// lcd video top level
// raster timing, pixel memory and shader on
// one clock, with plain ports at the boundary
//////////////////////////////////////////////////

module lcd_video_top (
  input logic clk_3_276mhz,
  input logic reset_n,
  // pixel writer
  input logic pixel_wr,
  input logic [video_pkg::pix_addr_width-1:0] pixel_wr_addr,
  input logic [video_pkg::pix_data_width-1:0] pixel_wr_data,
  // video out to the scaler
  output logic [23:0] video_rgb,
  output logic video_de,
  output logic video_vs,
  output logic video_hs
);

  import video_pkg::*;

  // raster bus between the blocks
  raster_if raster ();

  // nibble from memory to shader
  pix_data_t pixel;
  // shader colour before flattening
  rgb_t video_rgb_s;

  ////////////////////////////////////////////////
  // blocks

  raster_timing u_raster_timing (
    .clk_3_276mhz (clk_3_276mhz),
    .reset_n      (reset_n),
    .raster       (raster.source)
  );

  pixel_memory u_pixel_memory (
    .clk_3_276mhz  (clk_3_276mhz),
    .reset_n       (reset_n),
    .pixel_wr      (pixel_wr),
    .pixel_wr_addr (pixel_wr_addr),
    .pixel_wr_data (pixel_wr_data),
    .raster        (raster.sink),
    .pixel         (pixel)
  );

  pixel_shader u_pixel_shader (
    .clk_3_276mhz (clk_3_276mhz),
    .reset_n      (reset_n),
    .raster       (raster.sink),
    .pixel        (pixel),
    .video_rgb    (video_rgb_s),
    .video_de     (video_de),
    .video_vs     (video_vs),
    .video_hs     (video_hs)
  );

  // red in [23:16], blue in [7:0]
  assign video_rgb = video_rgb_s;

endmodule

// ==== verification/lcd_video_assertions.sv ====
//////////////////////////////////////////////////
// lcd video assertions
// blanking and sync rules on the shader outputs
//////////////////////////////////////////////////

module lcd_video_assertions (
  input logic clk_3_276mhz,
  input logic reset_n,
  input video_pkg::rgb_t video_rgb,
  input logic video_de,
  input logic video_vs,
  input logic video_hs
);

  timeunit 1ns;
  timeprecision 1ps;

  ////////////////////////////////////////////////
  // properties

  // syncs live in blanking only
  property no_sync_in_de;
    @(posedge clk_3_276mhz) disable iff (!reset_n)
      video_de |-> !(video_vs || video_hs);
  endproperty

  // vs at x 0, hs at x 3, never the same cycle
  property syncs_apart;
    @(posedge clk_3_276mhz) disable iff (!reset_n)
      !(video_vs && video_hs);
  endproperty

  // blanking is black
  property black_when_blank;
    @(posedge clk_3_276mhz) disable iff (!reset_n)
      !video_de |-> (video_rgb == '0);
  endproperty

  ////////////////////////////////////////////////
  // checks

  no_sync_in_de_a: assert property (no_sync_in_de)
    else $error("sync strobe high while data enable is high");

  syncs_apart_a: assert property (syncs_apart)
    else $error("vertical and horizontal sync high together");

  black_when_blank_a: assert property (black_when_blank)
    else $error("colour not black outside data enable");

endmodule

// one checker per shader instance
bind pixel_shader lcd_video_assertions u_lcd_video_assertions (
  .clk_3_276mhz (clk_3_276mhz),
  .reset_n      (reset_n),
  .video_rgb    (video_rgb),
  .video_de     (video_de),
  .video_vs     (video_vs),
  .video_hs     (video_hs)
);

// ==== verification/tb_lcd_video.sv ====
//////////////////////////////////////////////////
// lcd video testbench
// random pixel writes against a mirror model,
// checking syncs, data enable and colour for
// two full frames
//////////////////////////////////////////////////

module tb_lcd_video;

  timeunit 1ns;
  timeprecision 1ps;

  ////////////////////////////////////////////////
  // reference numbers for the raster

  localparam int clk_period = 100;
  localparam int drive_delay = 10;
  localparam int reset_cycles = 3;
  // 400 clocks per line, 512 lines per frame
  localparam int line_cycles = 400;
  localparam int frame_lines = 512;
  localparam int frame_cycles = line_cycles * frame_lines;
  // visible window 320 x 240 after a porch of 10
  localparam int de_first_x = 10;
  localparam int de_width = 320;
  localparam int de_first_y = 10;
  localparam int de_lines = 240;
  localparam int hs_offset = 3;
  localparam int run_frames = 2;
  localparam int run_cycles = run_frames * frame_cycles;
  // gray 60 on each channel
  localparam logic [23:0] lit_rgb = 24'h3c3c3c;
  // three frames plus reset, in ns
  localparam longint watchdog_ns =
    longint'(reset_cycles + 3 * frame_cycles) * clk_period;

  // dut ports
  logic clk_3_276mhz = 1'b0;
  logic reset_n;
  logic pixel_wr;
  logic [7:0] pixel_wr_addr;
  logic [3:0] pixel_wr_data;
  logic [23:0] video_rgb;
  logic video_de;
  logic video_vs;
  logic video_hs;

  // model state
  logic [3:0] mirror [256];
  logic [7:0] pixel_index;
  logic [31:0] rng_state;
  // tallies of what the dut drove
  int vs_seen;
  int hs_seen;
  int de_seen;
  int lit_seen;
  int dark_seen;
  // writes landing on the entry scanned that cycle
  int same_cycle_hits;

  lcd_video_top dut (
    .clk_3_276mhz  (clk_3_276mhz),
    .reset_n       (reset_n),
    .pixel_wr      (pixel_wr),
    .pixel_wr_addr (pixel_wr_addr),
    .pixel_wr_data (pixel_wr_data),
    .video_rgb     (video_rgb),
    .video_de      (video_de),
    .video_vs      (video_vs),
    .video_hs      (video_hs)
  );

  always #(clk_period / 2) clk_3_276mhz = ~clk_3_276mhz;

  ////////////////////////////////////////////////
  // helpers

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] s;
    s = state;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic check_value(input string test_name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERR %s expected %0h actual %0h", test_name, expected, actual);
      $display("Test failures found");
      $fatal(1, "%s mismatch", test_name);
    end
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Test failures found");
    $fatal(1, "run stopped");
  endtask

  // about one write in eight, a quarter of them zero
  task automatic draw_write();
    logic [31:0] r;
    rng_state = xorshift32(rng_state);
    r = rng_state;
    pixel_wr = (r[2:0] == 3'd0);
    pixel_wr_addr = r[15:8];
    if (r[21:20] == 2'd0) begin
      pixel_wr_data = 4'h0;
    end else if (r[19:16] == 4'h0) begin
      pixel_wr_data = 4'hf;
    end else begin
      pixel_wr_data = r[19:16];
    end
  endtask

  // outputs after an edge describe the raster at cycle t
  // the write sampled at that edge only lands afterwards
  task automatic check_cycle(input int t);
    int x;
    int y;
    logic exp_vs;
    logic exp_hs;
    logic exp_de;
    logic [23:0] exp_rgb;
    x = t % line_cycles;
    y = (t / line_cycles) % frame_lines;
    exp_vs = (x == 0) && (y == 0);
    exp_hs = (x == hs_offset);
    exp_de = (x >= de_first_x) && (x < de_first_x + de_width) &&
             (y >= de_first_y) && (y < de_first_y + de_lines);
    exp_rgb = (exp_de && mirror[pixel_index] != 4'h0) ? lit_rgb : 24'h0;

    check_value("video_vs", 32'(exp_vs), 32'(video_vs));
    check_value("video_hs", 32'(exp_hs), 32'(video_hs));
    check_value("video_de", 32'(exp_de), 32'(video_de));
    check_value("video_rgb", 32'(exp_rgb), 32'(video_rgb));

    if (video_vs) vs_seen++;
    if (video_hs) hs_seen++;
    if (video_de) de_seen++;

    // scan index moves on enabled pixels only
    if (exp_de) begin
      if (exp_rgb != 24'h0) begin
        lit_seen++;
      end else begin
        dark_seen++;
      end
      if (pixel_wr && pixel_wr_addr == pixel_index) begin
        same_cycle_hits++;
      end
      pixel_index = pixel_index + 8'd1;
    end

    if (pixel_wr) begin
      mirror[pixel_wr_addr] = pixel_wr_data;
    end
  endtask

  ////////////////////////////////////////////////
  // main sequence

  initial begin
    reset_n = 1'b0;
    pixel_wr = 1'b0;
    pixel_wr_addr = '0;
    pixel_wr_data = '0;
    rng_state = 32'hb01a;
    pixel_index = '0;
    vs_seen = 0;
    hs_seen = 0;
    de_seen = 0;
    lit_seen = 0;
    dark_seen = 0;
    same_cycle_hits = 0;
    // blank screen after reset
    for (int i = 0; i < 256; i++) begin
      mirror[i] = 4'h0;
    end

    repeat (reset_cycles) @(posedge clk_3_276mhz);
    #(drive_delay);
    // outputs idle while in reset
    check_value("reset video_de", 32'h0, 32'(video_de));
    check_value("reset video_vs", 32'h0, 32'(video_vs));
    check_value("reset video_hs", 32'h0, 32'(video_hs));
    check_value("reset video_rgb", 32'h0, 32'(video_rgb));
    reset_n = 1'b1;

    for (int t = 0; t < run_cycles; t++) begin
      @(posedge clk_3_276mhz);
      #(drive_delay);
      check_cycle(t);
      draw_write();
    end

    // totals over the two frames
    check_value("vs pulses", run_frames, vs_seen);
    check_value("hs pulses", run_frames * frame_lines, hs_seen);
    check_value("de cycles", run_frames * de_width * de_lines, de_seen);

    if (lit_seen == 0 || dark_seen == 0 || same_cycle_hits == 0) begin
      abort_run("random writes never produced lit, dark and same-cycle pixels");
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

  ////////////////////////////////////////////////
  // watchdog

  initial begin
    #(watchdog_ns);
    $display("watchdog expired, the run took longer than three frames");
    $display("Test failures found");
    $fatal(1, "timeout");
  end

endmodule

// ==== build.f ====
design/video_pkg.sv
design/raster_if.sv
design/raster_timing.sv
design/pixel_memory.sv
design/pixel_shader.sv
design/lcd_video_top.sv
verification/lcd_video_assertions.sv
verification/tb_lcd_video.sv

// ==== run.sh ====
#!/bin/sh
# compile the lcd video testbench with verilator and run it
# the simulator exit status carries pass or fail
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f build.f --top-module tb_lcd_video -o sim_lcd_video

./obj_dir/sim_lcd_video
